/* byte_stream_if.sv */
`timescale 1ns/1ps

// serialized bytes from the serializer into the checksum stage.
interface byte_stream_if;

	logic [7:0] data;
	logic       valid;
	logic       field_end;   // set with each field's SOH byte.
	logic       msg_end;     // set with the SOH of a last field.
	logic       hold;        // the trailer owns the output while this is high.

	modport serial_mp (
		output data,
		output valid,
		output field_end,
		output msg_end,
		input  hold
	);

	modport result_mp (
		input  data,
		input  valid,
		input  field_end,
		input  msg_end,
		output hold
	);

endinterface

/* field_if.sv */
`timescale 1ns/1ps

// one decoded field on its way from decode to the serializer.
interface field_if #(parameter int VALUE_BYTES = 32);

	logic                                valid;
	logic [fix_pkg::TAG_BYTES*8-1:0]     tag;
	logic [VALUE_BYTES*8-1:0]            val;
	fix_pkg::tag_len_t                   t_len;
	logic [7:0]                          v_len;
	logic                                last;
	logic                                take;   // one cycle, on the load edge.

	modport decode_mp (
		output valid,
		output tag,
		output val,
		output t_len,
		output v_len,
		output last,
		input  take
	);

	modport serial_mp (
		input  valid,
		input  tag,
		input  val,
		input  t_len,
		input  v_len,
		input  last,
		output take
	);

endinterface

/* filelist.f */
fix_pkg.sv
field_if.sv
byte_stream_if.sv
fix_field_decode.sv
fix_field_serializer.sv
fix_checksum_trailer.sv
fix_msg_create.sv
tb_clock_gen.sv
tb_fix_checker.sv
tb_fix_msg_create.sv

/* fix_checksum_trailer.sv */
`timescale 1ns/1ps

module fix_checksum_trailer (
	input  logic        clk,
	input  logic        rst,
	output logic [7:0]  data_o,
	output logic        data_valid_o,
	output logic        done_o,
	output logic        end_o,
	byte_stream_if.result_mp bs
);

	logic [7:0] sum;
	logic       trl_active;
	logic [2:0] tcnt;       // position in the 7-byte trailer.
	logic [3:0] hund;
	logic [6:0] rem;
	logic [3:0] tens;
	logic [3:0] units;
	logic [7:0] trl_byte;

	// hold goes up as soon as the last SOH shows up, and drops one cycle
	// early so the next message follows the trailer SOH without a gap.
	assign bs.hold = (trl_active && tcnt != 3'd6) || (bs.valid && bs.msg_end);

	always_comb begin
		case (tcnt)
			3'd0:    trl_byte = fix_pkg::ONE_BYTE;
			3'd1:    trl_byte = fix_pkg::ZERO_BYTE;
			3'd2:    trl_byte = fix_pkg::EQ_BYTE;
			3'd3:    trl_byte = fix_pkg::ZERO_BYTE + 8'(hund);
			3'd4:    trl_byte = fix_pkg::ZERO_BYTE + 8'(tens);
			3'd5:    trl_byte = fix_pkg::ZERO_BYTE + 8'(units);
			default: trl_byte = fix_pkg::SOH_BYTE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= '0;
			trl_active <= 1'b0;
			tcnt <= '0;
			data_valid_o <= 1'b0;
			done_o <= 1'b0;
			end_o <= 1'b0;
		end else if (trl_active) begin
			data_valid_o <= 1'b1;
			done_o <= (tcnt == 3'd6);
			end_o <= (tcnt == 3'd6);
			tcnt <= tcnt + 3'd1;
			if (tcnt == 3'd6) begin
				trl_active <= 1'b0;
				sum <= '0; // next message starts clean.
			end
		end else begin
			data_valid_o <= bs.valid;
			done_o <= bs.valid && bs.field_end;
			end_o <= 1'b0;
			if (bs.valid) begin
				sum <= sum + bs.data;
				if (bs.msg_end) begin
					trl_active <= 1'b1;
					tcnt <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (trl_active) begin
			data_o <= trl_byte;
		end else if (bs.valid) begin
			data_o <= bs.data;
		end
	end

	// decimal digits, one step per trailer byte, ready before "10=" is out.
	always_ff @(posedge clk) begin
		if (trl_active && tcnt == 3'd0) begin
			hund <= 4'(sum / 8'd100);
			rem <= 7'(sum % 8'd100);
		end
		if (trl_active && tcnt == 3'd1) begin
			tens <= 4'(rem / 7'd10);
			units <= 4'(rem % 7'd10);
		end
	end

endmodule

/* fix_field_decode.sv */
`timescale 1ns/1ps

module fix_field_decode #(
	parameter int VALUE_BYTES = 32
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            field_valid_i,
	input  logic [fix_pkg::TAG_BYTES*8-1:0] tag_i,
	input  fix_pkg::tag_len_t               t_size_i,
	input  logic [VALUE_BYTES*8-1:0]        val_i,
	input  logic [7:0]                      v_size_i,
	input  logic                            last_i,
	output logic                            ready_o,
	output logic                            error_o,
	field_if.decode_mp                      fld
);

	logic accept;
	logic t_ok;
	logic v_ok;

	// the one-entry buffer is empty whenever nothing is presented.
	assign ready_o = !fld.valid;
	assign accept = field_valid_i && ready_o;

	assign t_ok = (t_size_i != '0) && (t_size_i <= fix_pkg::tag_len_t'(fix_pkg::TAG_BYTES));
	assign v_ok = (v_size_i != '0) && (32'(v_size_i) <= 32'(VALUE_BYTES));

	always_ff @(posedge clk) begin
		if (rst) begin
			fld.valid <= 1'b0;
			error_o <= 1'b0;
		end else begin
			error_o <= accept && !(t_ok && v_ok);
			if (fld.take) begin
				fld.valid <= 1'b0;
			end else if (accept && t_ok && v_ok) begin
				fld.valid <= 1'b1;
			end
		end
	end

	// payload only moves on a legal accept, so the buffer holds while full.
	always_ff @(posedge clk) begin
		if (accept && t_ok && v_ok) begin
			fld.tag <= tag_i;
			fld.val <= val_i;
			fld.t_len <= t_size_i;
			fld.v_len <= v_size_i;
			fld.last <= last_i;
		end
	end

endmodule

/* fix_field_serializer.sv */
`timescale 1ns/1ps

module fix_field_serializer #(
	parameter int VALUE_BYTES = 32
) (
	input  logic         clk,
	input  logic         rst,
	field_if.serial_mp   fld,
	byte_stream_if.serial_mp bs
);

	fix_pkg::ser_state_t             state;
	logic [7:0]                      idx;      // byte index into tag or value.
	logic [fix_pkg::TAG_BYTES*8-1:0] tag_q;
	logic [VALUE_BYTES*8-1:0]        val_q;
	fix_pkg::tag_len_t               t_len_q;
	logic [7:0]                      v_len_q;
	logic                            last_q;
	logic                            emit;
	logic [7:0]                      byte_sel;

	// a field can be loaded from idle or right behind the previous SOH.
	assign fld.take = fld.valid && !bs.hold &&
		(state == fix_pkg::IDLE || state == fix_pkg::SOH);

	assign emit = !bs.hold && (state != fix_pkg::IDLE);

	always_comb begin
		case (state)
			fix_pkg::TAG: byte_sel = tag_q[idx[1:0]*8 +: 8];
			fix_pkg::EQ:  byte_sel = fix_pkg::EQ_BYTE;
			fix_pkg::VAL: byte_sel = val_q[idx*8 +: 8];
			default:      byte_sel = fix_pkg::SOH_BYTE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fix_pkg::IDLE;
			idx <= '0;
			bs.valid <= 1'b0;
			bs.field_end <= 1'b0;
			bs.msg_end <= 1'b0;
		end else begin
			bs.valid <= emit;
			bs.field_end <= 1'b0;
			bs.msg_end <= 1'b0;
			case (state)
				fix_pkg::IDLE: begin
					if (fld.take) begin
						state <= fix_pkg::TAG;
						idx <= '0;
					end
				end
				fix_pkg::TAG: begin
					if (emit) begin
						if (idx == 8'(t_len_q) - 8'd1) begin
							state <= fix_pkg::EQ;
							idx <= '0;
						end else begin
							idx <= idx + 8'd1;
						end
					end
				end
				fix_pkg::EQ: begin
					if (emit) state <= fix_pkg::VAL;
				end
				fix_pkg::VAL: begin
					if (emit) begin
						if (idx == v_len_q - 8'd1) begin
							state <= fix_pkg::SOH;
							idx <= '0;
						end else begin
							idx <= idx + 8'd1;
						end
					end
				end
				fix_pkg::SOH: begin
					if (emit) begin
						bs.field_end <= 1'b1;
						bs.msg_end <= last_q;
						state <= fld.take ? fix_pkg::TAG : fix_pkg::IDLE; // back to back fields.
					end
				end
				default: state <= fix_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (emit) bs.data <= byte_sel;
	end

	// local copy of the field, so decode can refill its buffer meanwhile.
	always_ff @(posedge clk) begin
		if (fld.take) begin
			tag_q <= fld.tag;
			val_q <= fld.val;
			t_len_q <= fld.t_len;
			v_len_q <= fld.v_len;
			last_q <= fld.last;
		end
	end

endmodule

/* fix_msg_create.sv */
`timescale 1ns/1ps

module fix_msg_create #(
	parameter int VALUE_BYTES = 32
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            field_valid_i,
	input  logic [fix_pkg::TAG_BYTES*8-1:0] tag_i,
	input  fix_pkg::tag_len_t               t_size_i,
	input  logic [VALUE_BYTES*8-1:0]        val_i,
	input  logic [7:0]                      v_size_i,
	input  logic                            last_i,
	output logic                            ready_o,
	output logic                            error_o,
	output logic [7:0]                      data_o,
	output logic                            data_valid_o,
	output logic                            done_o,
	output logic                            end_o
);

	field_if #(.VALUE_BYTES(VALUE_BYTES)) fld ();
	byte_stream_if bs ();

	fix_field_decode #(.VALUE_BYTES(VALUE_BYTES)) u_decode (
		.clk           (clk),
		.rst           (rst),
		.field_valid_i (field_valid_i),
		.tag_i         (tag_i),
		.t_size_i      (t_size_i),
		.val_i         (val_i),
		.v_size_i      (v_size_i),
		.last_i        (last_i),
		.ready_o       (ready_o),
		.error_o       (error_o),
		.fld           (fld.decode_mp)
	);

	fix_field_serializer #(.VALUE_BYTES(VALUE_BYTES)) u_serializer (
		.clk (clk),
		.rst (rst),
		.fld (fld.serial_mp),
		.bs  (bs.serial_mp)
	);

	// output register stage and checksum trailer.
	fix_checksum_trailer u_trailer (
		.clk          (clk),
		.rst          (rst),
		.data_o       (data_o),
		.data_valid_o (data_valid_o),
		.done_o       (done_o),
		.end_o        (end_o),
		.bs           (bs.result_mp)
	);

endmodule

/* fix_pkg.sv */
package fix_pkg;

	// field framing bytes.
	localparam logic [7:0] SOH_BYTE = 8'h01;
	localparam logic [7:0] EQ_BYTE = 8'h3d;

	// trailer tag "10" in ascii.
	localparam logic [7:0] ONE_BYTE = 8'h31;
	localparam logic [7:0] ZERO_BYTE = 8'h30;

	localparam int TAG_BYTES = 4;

	// wide enough to hold the illegal sizes 0 and 5 as well.
	typedef logic [2:0] tag_len_t;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		TAG  = 3'd1,
		EQ   = 3'd2,
		VAL  = 3'd3,
		SOH  = 3'd4
	} ser_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and scan the log for the fail message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_fix_msg_create -f filelist.f -o sim_fix

./obj_dir/sim_fix > sim.log
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset is released on a falling edge, like every other DUT input.
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

/* tb_fix_checker.sv */
`timescale 1ns/1ps

module tb_fix_checker #(
	parameter int VALUE_BYTES = 32
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     field_valid_i,
	input  logic [31:0]              tag_i,
	input  logic [2:0]               t_size_i,
	input  logic [VALUE_BYTES*8-1:0] val_i,
	input  logic [7:0]               v_size_i,
	input  logic                     last_i,
	input  logic                     expect_error_i,
	input  logic                     ready_i,
	input  logic                     error_i,
	input  logic [7:0]               data_i,
	input  logic                     data_valid_i,
	input  logic                     done_i,
	input  logic                     end_i,
	output int                       mismatch_count_o,
	output int                       fault_count_o,
	output int                       pending_o
);

	logic [9:0] exp_q[$];   // {end, done, byte} in output order.
	logic [7:0] run_sum;
	logic       err_due;
	logic       in_reset;

	initial begin
		mismatch_count_o = 0;
		fault_count_o = 0;
		pending_o = 0;
		run_sum = '0;
		err_due = 1'b0;
		in_reset = 1'b0;
	end

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %02h, got %02h", $time, name, exp, act);
			mismatch_count_o++;
		end
	endtask

	task automatic push_field_byte(input logic [7:0] b, input logic done);
		exp_q.push_back({1'b0, done, b});
		run_sum = run_sum + b;
	endtask

	// tag and value go out least significant byte first.
	task automatic enqueue_field();
		for (int i = 0; i < int'(t_size_i); i++) push_field_byte(8'(tag_i >> (i * 8)), 1'b0);
		push_field_byte(fix_pkg::EQ_BYTE, 1'b0);
		for (int i = 0; i < int'(v_size_i); i++) push_field_byte(8'(val_i >> (i * 8)), 1'b0);
		push_field_byte(fix_pkg::SOH_BYTE, 1'b1);
		if (last_i) begin
			exp_q.push_back({2'b00, 8'h31});
			exp_q.push_back({2'b00, 8'h30});
			exp_q.push_back({2'b00, fix_pkg::EQ_BYTE});
			exp_q.push_back({2'b00, 8'h30 + run_sum / 8'd100});
			exp_q.push_back({2'b00, 8'h30 + (run_sum / 8'd10) % 8'd10});
			exp_q.push_back({2'b00, 8'h30 + run_sum % 8'd10});
			exp_q.push_back({2'b11, fix_pkg::SOH_BYTE});
			run_sum = '0; // the trailer closes the message.
		end
	endtask

	always @(posedge clk_i) begin
		logic [9:0] head;
		if (rst_i) begin
			in_reset = 1'b1;
			err_due = 1'b0;
		end else begin
			if (in_reset) begin
				check_value("ready_o", 8'h01, 8'(ready_i));
				check_value("data_valid_o", 8'h00, 8'(data_valid_i));
				check_value("done_o", 8'h00, 8'(done_i));
				check_value("end_o", 8'h00, 8'(end_i));
				in_reset = 1'b0;
			end
			check_value("error_o", 8'(err_due), 8'(error_i));
			err_due = 1'b0;
			if (field_valid_i && ready_i) begin
				if (expect_error_i) err_due = 1'b1;
				else enqueue_field();
			end
			if (data_valid_i) begin
				if (exp_q.size() == 0) begin
					$display("byte %02h came out on data_o at %0t with nothing expected", data_i, $time);
					fault_count_o++;
				end else begin
					head = exp_q.pop_front();
					check_value("data_o", head[7:0], data_i);
					check_value("done_o", 8'(head[8]), 8'(done_i));
					check_value("end_o", 8'(head[9]), 8'(end_i));
				end
			end else if (done_i || end_i) begin
				$display("done_o or end_o went high at %0t without data_valid_o", $time);
				fault_count_o++;
			end
		end
		pending_o = exp_q.size();
	end

endmodule

/* tb_fix_msg_create.sv */
`timescale 1ns/1ps

module tb_fix_msg_create;

	localparam int VALUE_BYTES = 32;

	typedef struct packed {
		logic [31:0]              tag;
		logic [2:0]               t_size;
		logic [VALUE_BYTES*8-1:0] val;
		logic [7:0]               v_size;
		logic                     last;
		logic [7:0]               gap;      // idle cycles after the strobe.
		logic                     rnd;      // tag and value come from the LFSR.
		logic                     exp_err;  // illegal sizes make error_o pulse.
	} entry_t;

	logic                     clk;
	logic                     rst;
	logic                     field_valid_i;
	logic [31:0]              tag_i;
	logic [2:0]               t_size_i;
	logic [VALUE_BYTES*8-1:0] val_i;
	logic [7:0]               v_size_i;
	logic                     last_i;
	logic                     expect_error;
	logic                     ready_o;
	logic                     error_o;
	logic [7:0]               data_o;
	logic                     data_valid_o;
	logic                     done_o;
	logic                     end_o;
	int                       mismatch_count;
	int                       fault_count;
	int                       pending;
	int                       cycle_count;
	int                       cycle_limit;
	logic [31:0]              lfsr_state;
	entry_t                   stim_q[$];

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.clk_o(clk), .rst_o(rst));

	fix_msg_create #(.VALUE_BYTES(VALUE_BYTES)) UUT (.*);

	tb_fix_checker #(.VALUE_BYTES(VALUE_BYTES)) u_checker (
		.clk_i            (clk),
		.rst_i            (rst),
		.field_valid_i,
		.tag_i,
		.t_size_i,
		.val_i,
		.v_size_i,
		.last_i,
		.expect_error_i   (expect_error),
		.ready_i          (ready_o),
		.error_i          (error_o),
		.data_i           (data_o),
		.data_valid_i     (data_valid_o),
		.done_i           (done_o),
		.end_i            (end_o),
		.mismatch_count_o (mismatch_count),
		.fault_count_o    (fault_count),
		.pending_o        (pending)
	);

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_random(input int nbits, output logic [VALUE_BYTES*8-1:0] r);
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[VALUE_BYTES*8-2:0], lfsr_state[0]};
		end
	endtask

	task automatic add_entry(input logic [31:0] tag, input logic [2:0] t_size,
			input logic [VALUE_BYTES*8-1:0] val, input logic [7:0] v_size, input logic last,
			input logic [7:0] gap, input logic rnd, input logic exp_err);
		stim_q.push_back('{tag, t_size, val, v_size, last, gap, rnd, exp_err});
	endtask

	task automatic build_table();
		add_entry(32'h0000_3534, 3'd2, 256'h4231, 8'd2, 1'b0, 8'd10, 1'b0, 1'b0);
		add_entry(32'h0037_3331, 3'd3, 256'h4443_4241, 8'd4, 1'b1, 8'd12, 1'b0, 1'b0);
		add_entry(32'h3532_3934, 3'd4, 256'h5a, 8'd1, 1'b1, 8'd12, 1'b0, 1'b0);
		add_entry(32'h38, 3'd1, 256'h3130, 8'd2, 1'b0, 8'd0, 1'b0, 1'b0);
		add_entry(32'h3938, 3'd2, 256'h33, 8'd1, 1'b0, 8'd0, 1'b0, 1'b0);
		add_entry(32'h36_3534, 3'd3, 256'h4645_4443, 8'd4, 1'b0, 8'd0, 1'b0, 1'b0);
		add_entry(32'h37, 3'd1, 256'h39, 8'd1, 1'b0, 8'd20, 1'b0, 1'b0);
		add_entry(32'h3135, 3'd2, 256'h59, 8'd1, 1'b1, 8'd20, 1'b0, 1'b0);
		add_entry(32'h31, 3'd0, 256'h31, 8'd1, 1'b0, 8'd3, 1'b0, 1'b1);
		add_entry(32'h3433_3231, 3'd5, 256'h31, 8'd1, 1'b0, 8'd3, 1'b0, 1'b1);
		add_entry(32'h31, 3'd1, 256'h31, 8'd0, 1'b0, 8'd3, 1'b0, 1'b1);
		add_entry(32'h31, 3'd1, 256'h31, 8'd33, 1'b1, 8'd3, 1'b0, 1'b1);
		add_entry('0, 3'd1, '0, 8'd1, 1'b0, 8'd2, 1'b1, 1'b0);
		add_entry('0, 3'd4, '0, 8'd32, 1'b0, 8'd2, 1'b1, 1'b0);
		add_entry('0, 3'd1, '0, 8'd32, 1'b0, 8'd2, 1'b1, 1'b0);
		add_entry('0, 3'd4, '0, 8'd1, 1'b1, 8'd2, 1'b1, 1'b0);
		add_entry('0, 3'd4, '0, 8'd32, 1'b0, 8'd0, 1'b1, 1'b0);
		add_entry('0, 3'd2, '0, 8'd16, 1'b1, 8'd30, 1'b1, 1'b0);
		add_entry('0, 3'd1, '0, 8'd32, 1'b1, 8'd40, 1'b1, 1'b0);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d bytes still expected", cycle_count, pending);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		entry_t                   e;
		logic [VALUE_BYTES*8-1:0] rbits;
		logic [7:0]               prev_gap;
		field_valid_i = 1'b0;
		tag_i = '0;
		t_size_i = '0;
		val_i = '0;
		v_size_i = '0;
		last_i = 1'b0;
		expect_error = 1'b0;
		cycle_count = 0;
		cycle_limit = 0;
		lfsr_state = 32'h95cb_139d;
		build_table();
		foreach (stim_q[i]) begin
			e = stim_q[i];
			cycle_limit += int'(e.t_size) + int'(e.v_size) + 2 + int'(e.gap) + 4;
			cycle_limit += e.last ? 7 : 0;
		end
		cycle_limit += 16 + 50;
		prev_gap = 8'd1;
		@(posedge clk);
		while (rst !== 1'b0) @(posedge clk);
		@(negedge clk);
		foreach (stim_q[i]) begin
			e = stim_q[i];
			// back to back entries strobe blindly so that some get dropped.
			if (prev_gap != 8'd0) while (!ready_o) @(negedge clk);
			if (e.rnd) begin
				take_random(int'(e.t_size) * 8, rbits);
				e.tag = rbits[31:0];
				take_random(int'(e.v_size) * 8, rbits);
				e.val = rbits;
			end
			tag_i = e.tag;
			t_size_i = e.t_size;
			val_i = e.val;
			v_size_i = e.v_size;
			last_i = e.last;
			expect_error = e.exp_err;
			field_valid_i = 1'b1;
			@(negedge clk);
			field_valid_i = 1'b0;
			repeat (e.gap) @(negedge clk);
			prev_gap = e.gap;
		end
		while (pending != 0 || !ready_o) @(negedge clk);
		repeat (4) @(negedge clk);
		$display("errors: %0d value mismatches, %0d other failures", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
